/* project.f */
source/rv_pkg.sv
source/reg_file.sv
source/imm_gen.sv
source/decoder.sv
source/alu.sv
source/lsu.sv
source/rv_core.sv
dv/tb_mem.sv
dv/tb_rv_core.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_rv_core -Mdir obj_dir -f project.f \
  && ./obj_dir/Vtb_rv_core | tee sim.log \
  && grep -qx "RESULT: PASS" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

/* dv/tb_rv_core.sv */
`timescale 1ns/100ps

module tb_rv_core;

  localparam rv_pkg::word_t DATA_BASE = rv_pkg::RESET_PC + 32'h400;
  // program words of reset, arith, load/store, branch, jump and halt tests
  localparam int PROG_WORDS     = 4 + 45 + 37 + 68 + 15 + 4;
  localparam int TIMEOUT_CYCLES = PROG_WORDS + 6 * 50;

  // add sub sll slt sltu xor srl sra or and
  localparam rv_pkg::funct3_t ARITH_F3 [10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3,
                                                3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
  localparam logic [9:0] ARITH_ALT = 10'b00_1000_0010; // sub and sra
  localparam rv_pkg::funct3_t BR_F3 [6] = '{rv_pkg::F3_BEQ, rv_pkg::F3_BNE, rv_pkg::F3_BLT,
                                            rv_pkg::F3_BGE, rv_pkg::F3_BLTU, rv_pkg::F3_BGEU};

  logic               clk;
  logic               rst_n;
  rv_pkg::word_t      imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
  rv_pkg::byte_mask_t dmem_wmask;
  logic               dmem_we;
  logic               halt;

  int seed = 42;
  int errors = 0;
  int tests = 0;
  int cycle_count = 0;

  rv_pkg::word_t      prog [$];
  rv_pkg::word_t      exp_addr [$], exp_data [$], seen_addr [$], seen_data [$];
  rv_pkg::byte_mask_t exp_mask [$], seen_mask [$];

  rv_core DUT (
    .clk(clk), .rst_n(rst_n), .imem_addr(imem_addr), .imem_rdata(imem_rdata),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask),
    .dmem_we(dmem_we), .dmem_rdata(dmem_rdata), .halt(halt)
  );

  tb_mem u_mem (
    .clk(clk), .imem_addr(imem_addr), .imem_rdata(imem_rdata), .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata), .dmem_wmask(dmem_wmask), .dmem_we(dmem_we),
    .dmem_rdata(dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the core did not reach ebreak within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // every committed store, sampled on the edge that writes it
  always @(posedge clk) begin
    if (dmem_we) begin
      seen_addr.push_back(dmem_addr);
      seen_data.push_back(dmem_wdata);
      seen_mask.push_back(dmem_wmask);
    end
  end

  function automatic rv_pkg::word_t rtype(input rv_pkg::funct3_t f3, input logic alt,
                                          input rv_pkg::reg_idx_t rd, rs1, rs2);
    return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_pkg::OP_REG};
  endfunction

  function automatic rv_pkg::word_t itype(input logic [6:0] op, input rv_pkg::funct3_t f3,
                                          input rv_pkg::reg_idx_t rd, rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t stype(input rv_pkg::funct3_t f3,
                                          input rv_pkg::reg_idx_t rs1, rs2,
                                          input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic rv_pkg::word_t btype(input rv_pkg::funct3_t f3,
                                          input rv_pkg::reg_idx_t rs1, rs2,
                                          input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
  endfunction

  function automatic rv_pkg::word_t utype(input logic [6:0] op, input rv_pkg::reg_idx_t rd,
                                          input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic rv_pkg::word_t jtype(input rv_pkg::reg_idx_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
  endfunction

  // RV32I result rules
  function automatic rv_pkg::word_t expect_alu(input rv_pkg::funct3_t f3, input logic alt,
                                               input rv_pkg::word_t a, b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input rv_pkg::funct3_t f3, input rv_pkg::word_t a, b);
    case (f3)
      rv_pkg::F3_BEQ:  return a == b;
      rv_pkg::F3_BNE:  return a != b;
      rv_pkg::F3_BLT:  return $signed(a) < $signed(b);
      rv_pkg::F3_BGE:  return $signed(a) >= $signed(b);
      rv_pkg::F3_BLTU: return a < b;
      default:         return a >= b;
    endcase
  endfunction

  task automatic check_word(input string what, input rv_pkg::word_t got, exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_mask(input string what, input rv_pkg::byte_mask_t got, exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, exp);
    if (got !== exp) begin
      $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    exp_mask.delete();
  endtask

  task automatic add_store(input rv_pkg::word_t addr, data, input rv_pkg::byte_mask_t mask);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_mask.push_back(mask);
  endtask

  // lui plus addi, the upper part rounds up when the low 12 bits go negative
  task automatic load_const(input rv_pkg::reg_idx_t rd, input rv_pkg::word_t val);
    rv_pkg::word_t hi;
    hi = val + 32'h800;
    prog.push_back(utype(rv_pkg::OP_LUI, rd, hi[31:12]));
    prog.push_back(itype(rv_pkg::OP_IMM, rv_pkg::F3_ADD, rd, rd, val[11:0]));
  endtask

  // sw rs2 into result slot, x1 holds DATA_BASE
  task automatic store_word(input rv_pkg::reg_idx_t rs2, input int slot,
                            input rv_pkg::word_t value);
    prog.push_back(stype(rv_pkg::F3_SW, 1, rs2, 12'(4 * slot)));
    add_store(DATA_BASE + 32'(4 * slot), value, 4'b1111);
  endtask

  task automatic run_program();
    for (int i = 0; i < 1024; i++) begin
      u_mem.load_word(10'(i), (i < prog.size()) ? prog[i] : '0);
    end
    seen_addr.delete();
    seen_data.delete();
    seen_mask.delete();
    rst_n = 1'b0;
    repeat (10) begin
      @(negedge clk);
      check_word("imem_addr in reset", imem_addr, rv_pkg::RESET_PC);
      check_bit("dmem_we in reset", dmem_we, 1'b0);
    end
    rst_n = 1'b1;
    #1;
    check_word("imem_addr after reset", imem_addr, rv_pkg::RESET_PC);
    check_bit("dmem_we after reset", dmem_we, 1'b0);
    while (!halt) begin
      @(negedge clk);
    end
  endtask

  task automatic compare_stores(input string name, input int err_before);
    int n;
    n = (seen_addr.size() < exp_addr.size()) ? seen_addr.size() : exp_addr.size();
    if (seen_addr.size() != exp_addr.size()) begin
      $display("%s: expected %0d stores but the core made %0d", name, exp_addr.size(),
               seen_addr.size());
      errors++;
    end
    for (int i = 0; i < n; i++) begin
      check_word($sformatf("%s store %0d address", name, i), seen_addr[i], exp_addr[i]);
      check_word($sformatf("%s store %0d data", name, i), seen_data[i], exp_data[i]);
      check_mask($sformatf("%s store %0d mask", name, i), seen_mask[i], exp_mask[i]);
    end
    tests++;
    $display("test %-8s %0d stores, %0d errors", name, exp_addr.size(), errors - err_before);
  endtask

  task automatic test_reset();
    int err_before = errors;
    new_program();
    load_const(1, DATA_BASE);
    store_word(1, 4, DATA_BASE);
    prog.push_back(rv_pkg::EBREAK_INSN);
    run_program();
    compare_stores("reset", err_before);
  endtask

  task automatic test_arith();
    int            err_before = errors;
    int            slot = 0;
    rv_pkg::word_t a, b, opnd;
    logic [11:0]   imm;
    new_program();
    a = $random(seed);
    b = $random(seed);
    load_const(1, DATA_BASE);
    load_const(2, a);
    load_const(3, b);
    for (int k = 0; k < 10; k++) begin
      prog.push_back(rtype(ARITH_F3[k], ARITH_ALT[k], 4, 2, 3));
      store_word(4, slot++, expect_alu(ARITH_F3[k], ARITH_ALT[k], a, b));
    end
    for (int k = 0; k < 10; k++) begin
      if (k == 1) continue; // no subi
      if ((ARITH_F3[k] == rv_pkg::F3_SLL) || (ARITH_F3[k] == rv_pkg::F3_SR)) begin
        imm  = {1'b0, ARITH_ALT[k], 5'b0, 5'($random(seed))};
        opnd = {27'b0, imm[4:0]};
      end else begin
        imm  = 12'($random(seed));
        opnd = {{20{imm[11]}}, imm};
      end
      prog.push_back(itype(rv_pkg::OP_IMM, ARITH_F3[k], 4, 2, imm));
      store_word(4, slot++, expect_alu(ARITH_F3[k], ARITH_ALT[k], a, opnd));
    end
    prog.push_back(rv_pkg::EBREAK_INSN);
    run_program();
    compare_stores("arith", err_before);
  endtask

  task automatic test_ldst();
    int            err_before = errors;
    int            slot = 4;
    rv_pkg::word_t v;
    logic [7:0]    lane;
    logic [15:0]   half;
    new_program();
    v = ($random(seed) & 32'hFFFF_7FFF) | 32'h8080_0080; // bytes 0, 2, 3 negative
    load_const(1, DATA_BASE);
    load_const(2, v);
    for (int off = 0; off < 4; off++) begin
      prog.push_back(stype(rv_pkg::F3_SB, 1, 2, 12'(off)));
      add_store(DATA_BASE, {4{v[7:0]}}, 4'b0001 << off);
    end
    prog.push_back(stype(rv_pkg::F3_SH, 1, 2, 12'h000));
    add_store(DATA_BASE, {2{v[15:0]}}, 4'b0011);
    prog.push_back(stype(rv_pkg::F3_SH, 1, 2, 12'h002));
    add_store(DATA_BASE, {2{v[15:0]}}, 4'b1100);
    prog.push_back(stype(rv_pkg::F3_SW, 1, 2, 12'h000));
    add_store(DATA_BASE, v, 4'b1111);
    prog.push_back(stype(rv_pkg::F3_SH, 1, 2, 12'h001)); // misaligned, no write
    for (int u = 0; u < 2; u++) begin
      for (int off = 0; off < 4; off++) begin
        lane = v[8*off +: 8];
        prog.push_back(itype(rv_pkg::OP_LOAD, u ? rv_pkg::F3_LBU : rv_pkg::F3_LB, 3, 1,
                             12'(off)));
        store_word(3, slot++, u ? {24'b0, lane} : {{24{lane[7]}}, lane});
      end
      for (int off = 0; off < 4; off += 2) begin
        half = v[8*off +: 16];
        prog.push_back(itype(rv_pkg::OP_LOAD, u ? rv_pkg::F3_LHU : rv_pkg::F3_LH, 3, 1,
                             12'(off)));
        store_word(3, slot++, u ? {16'b0, half} : {{16{half[15]}}, half});
      end
    end
    prog.push_back(rv_pkg::EBREAK_INSN);
    run_program();
    compare_stores("ldst", err_before);
  endtask

  task automatic test_branch();
    int            err_before = errors;
    int            slot;
    rv_pkg::word_t a, b;
    new_program();
    load_const(1, DATA_BASE);
    prog.push_back(itype(rv_pkg::OP_IMM, rv_pkg::F3_ADD, 4, 0, 12'h5A5)); // marker
    for (int p = 0; p < 4; p++) begin
      a = $random(seed);
      b = $random(seed);
      if (p == 2) b = a ^ 32'h8000_0000; // signed and unsigned order disagree
      if (p == 3) b = a;
      load_const(2, a);
      load_const(3, b);
      for (int k = 0; k < 6; k++) begin
        slot = 6 * p + k;
        prog.push_back(btype(BR_F3[k], 2, 3, 13'd8)); // taken skips the store
        if (branch_taken(BR_F3[k], a, b)) begin
          prog.push_back(stype(rv_pkg::F3_SW, 1, 4, 12'(4 * slot)));
        end else begin
          store_word(4, slot, 32'h0000_05A5);
        end
      end
    end
    prog.push_back(rv_pkg::EBREAK_INSN);
    run_program();
    compare_stores("branch", err_before);
  endtask

  task automatic test_jump();
    int            err_before = errors;
    logic [19:0]   up_a, up_l;
    rv_pkg::word_t pc0;
    new_program();
    pc0  = rv_pkg::RESET_PC;
    up_a = 20'($random(seed));
    up_l = 20'($random(seed));
    load_const(1, DATA_BASE);                                   // 0, 4
    prog.push_back(jtype(5, 21'd12));                           // 8 to 20
    prog.push_back(rv_pkg::EBREAK_INSN);                        // 12 skipped
    prog.push_back(rv_pkg::EBREAK_INSN);                        // 16 skipped
    store_word(5, 0, pc0 + 32'd12);                             // 20
    prog.push_back(utype(rv_pkg::OP_AUIPC, 6, up_a));           // 24
    store_word(6, 1, pc0 + 32'd24 + {up_a, 12'b0});             // 28
    prog.push_back(utype(rv_pkg::OP_LUI, 7, up_l));             // 32
    store_word(7, 2, {up_l, 12'b0});                            // 36
    prog.push_back(utype(rv_pkg::OP_AUIPC, 8, 20'h0));          // 40
    prog.push_back(itype(rv_pkg::OP_JALR, 3'b000, 9, 8, 12'd13)); // 44, 53 rounds to 52
    prog.push_back(rv_pkg::EBREAK_INSN);                        // 48 skipped
    store_word(9, 3, pc0 + 32'd48);                             // 52
    prog.push_back(rv_pkg::EBREAK_INSN);                        // 56
    run_program();
    compare_stores("jump", err_before);
  endtask

  task automatic test_halt();
    int err_before = errors;
    new_program();
    load_const(1, DATA_BASE);
    prog.push_back(rv_pkg::EBREAK_INSN);
    prog.push_back(stype(rv_pkg::F3_SW, 1, 1, 12'h000)); // must never commit
    run_program();
    repeat (20) begin
      check_bit("halt", halt, 1'b1);
      check_word("imem_addr at ebreak", imem_addr, rv_pkg::RESET_PC + 32'd8);
      check_bit("dmem_we while halted", dmem_we, 1'b0);
      @(negedge clk);
    end
    compare_stores("halt", err_before);
  endtask

  initial begin
    rst_n = 1'b0;
    @(negedge clk);
    test_reset();
    test_arith();
    test_ldst();
    test_branch();
    test_jump();
    test_halt();
    $display("tests run %0d, errors %0d", tests, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* dv/tb_mem.sv */
`timescale 1ns/100ps

module tb_mem (
  input  logic               clk,
  input  rv_pkg::word_t      imem_addr,
  output rv_pkg::word_t      imem_rdata,
  input  rv_pkg::word_t      dmem_addr,
  input  rv_pkg::word_t      dmem_wdata,
  input  rv_pkg::byte_mask_t dmem_wmask,
  input  logic               dmem_we,
  output rv_pkg::word_t      dmem_rdata
);

  localparam int WORDS = 1024; // 4 KiB, upper address bits ignored

  rv_pkg::word_t mem [WORDS];
  rv_pkg::word_t merged;       // current word with the masked lanes replaced

  // both ports answer in the same cycle
  assign imem_rdata = mem[imem_addr[11:2]];
  assign dmem_rdata = mem[dmem_addr[11:2]];

  always_comb begin
    merged = dmem_rdata;
    for (int i = 0; i < 4; i++) begin
      if (dmem_wmask[i]) begin
        merged[8*i +: 8] = dmem_wdata[8*i +: 8];
      end
    end
  end

  always @(posedge clk) begin
    if (dmem_we) begin
      mem[dmem_addr[11:2]] <= merged;
    end
  end

  // program loading from the testbench, word index from the reset address
  task automatic load_word(input logic [9:0] idx, input rv_pkg::word_t data);
    mem[idx] <= data;
  endtask

endmodule

/* source/rv_core.sv */
`timescale 1ns/100ps

module rv_core (
  input  logic               clk,
  input  logic               rst_n,
  output rv_pkg::word_t      imem_addr,
  input  rv_pkg::word_t      imem_rdata,
  output rv_pkg::word_t      dmem_addr,
  output rv_pkg::word_t      dmem_wdata,
  output rv_pkg::byte_mask_t dmem_wmask,
  output logic               dmem_we,
  input  rv_pkg::word_t      dmem_rdata,
  output logic               halt
);

  rv_pkg::word_t      pc, pc4, next_pc;
  rv_pkg::word_t      pc_base, pc_rel, jump_target;
  rv_pkg::word_t      imm, rs1_data, rs2_data, alu_b, alu_result;
  rv_pkg::word_t      load_data, wb_data;
  rv_pkg::byte_mask_t st_mask;
  rv_pkg::alu_op_t    alu_op;
  rv_pkg::imm_sel_t   imm_sel;
  rv_pkg::wb_sel_t    wb_sel;
  logic               reg_we, use_imm, is_branch, is_jal, is_jalr, is_store;
  logic               cond;

  decoder u_decoder (
    .insn(imem_rdata), .reg_we(reg_we), .alu_op(alu_op), .use_imm(use_imm),
    .imm_sel(imm_sel), .wb_sel(wb_sel), .is_branch(is_branch), .is_jal(is_jal),
    .is_jalr(is_jalr), .is_store(is_store), .halt(halt)
  );

  imm_gen u_imm_gen (.insn(imem_rdata), .imm_sel(imm_sel), .imm(imm));

  reg_file u_reg_file (
    .clk(clk), .rst_n(rst_n), .we(reg_we && !halt), .waddr(imem_rdata[11:7]),
    .wdata(wb_data), .rs1_addr(imem_rdata[19:15]), .rs2_addr(imem_rdata[24:20]),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign alu_b = use_imm ? imm : rs2_data;

  alu u_alu (
    .a(rs1_data), .b(alu_b), .op(alu_op), .funct3(imem_rdata[14:12]),
    .result(alu_result), .cond(cond)
  );

  lsu u_lsu (
    .funct3(imem_rdata[14:12]), .addr_low(alu_result[1:0]), .is_store(is_store),
    .rs2_data(rs2_data), .rdata(dmem_rdata), .load_data(load_data),
    .wdata(dmem_wdata), .wmask(st_mask)
  );

  assign pc4 = pc + 32'd4;

  // one adder for branch, jal, jalr and auipc targets
  assign pc_base     = is_jalr ? rs1_data : pc;
  assign pc_rel      = pc_base + imm;
  assign jump_target = {pc_rel[31:1], pc_rel[0] & ~is_jalr};

  assign next_pc = (is_jal || is_jalr || (is_branch && cond)) ? jump_target : pc4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= rv_pkg::RESET_PC;
    end else if (!halt) begin // ebreak parks here until reset
      pc <= next_pc;
    end
  end

  always_comb begin
    case (wb_sel)
      rv_pkg::WB_LOAD:  wb_data = load_data;
      rv_pkg::WB_PC4:   wb_data = pc4;
      rv_pkg::WB_IMM:   wb_data = imm;
      rv_pkg::WB_PCREL: wb_data = pc_rel;
      default:          wb_data = alu_result;
    endcase
  end

  assign imem_addr  = pc;
  assign dmem_addr  = {alu_result[31:2], 2'b00};
  assign dmem_wmask = st_mask;
  // zero mask means misaligned, drop the write
  assign dmem_we    = is_store && (st_mask != '0) && !halt && rst_n;

  // every path into pc must keep it word aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("rv_core: misaligned pc %h", pc);

endmodule

/* source/lsu.sv */
`timescale 1ns/100ps

module lsu (
  input  rv_pkg::funct3_t    funct3,
  input  logic [1:0]         addr_low,
  input  logic               is_store,
  input  rv_pkg::word_t      rs2_data,
  input  rv_pkg::word_t      rdata,
  output rv_pkg::word_t      load_data,
  output rv_pkg::word_t      wdata,
  output rv_pkg::byte_mask_t wmask
);

  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  // lane picks from the full word
  assign ld_byte = rdata[8*addr_low +: 8];
  assign ld_half = addr_low[1] ? rdata[31:16] : rdata[15:0];

  // misaligned loads return zero
  always_comb begin
    case (funct3)
      rv_pkg::F3_LB:  load_data = {{24{ld_byte[7]}}, ld_byte};
      rv_pkg::F3_LBU: load_data = {24'b0, ld_byte};
      rv_pkg::F3_LH:  load_data = addr_low[0] ? '0 : {{16{ld_half[15]}}, ld_half};
      rv_pkg::F3_LHU: load_data = addr_low[0] ? '0 : {16'b0, ld_half};
      rv_pkg::F3_LW:  load_data = (addr_low == 2'b00) ? rdata : '0;
      default:        load_data = '0;
    endcase
  end

  // replicate so the mask alone picks the lanes
  always_comb begin
    case (funct3)
      rv_pkg::F3_SB: wdata = {4{rs2_data[7:0]}};
      rv_pkg::F3_SH: wdata = {2{rs2_data[15:0]}};
      default:       wdata = rs2_data;
    endcase
  end

  always_comb begin
    wmask = '0;
    if (is_store) begin
      case (funct3)
        rv_pkg::F3_SB: wmask = 4'b0001 << addr_low;
        rv_pkg::F3_SH: begin
          if (!addr_low[0]) begin
            wmask = addr_low[1] ? 4'b1100 : 4'b0011;
          end
        end
        rv_pkg::F3_SW: begin
          if (addr_low == 2'b00) begin
            wmask = 4'b1111;
          end
        end
        default: ;
      endcase
    end
  end

  // one, two or four adjacent lanes, never three
  always_comb begin
    a_mask_shape: assert (wmask inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                        4'b0011, 4'b0110, 4'b1100, 4'b1111})
      else $error("lsu: bad write mask %b", wmask);
  end

endmodule

/* source/alu.sv */
`timescale 1ns/100ps

module alu (
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::alu_op_t op,
  input  rv_pkg::funct3_t funct3,
  output rv_pkg::word_t   result,
  output logic            cond
);

  logic          do_sub;
  rv_pkg::word_t b_eff;   // b, or its complement when subtracting
  rv_pkg::word_t sum;
  logic          carry;
  logic          ovf;
  logic          lt;      // signed a < b
  logic          ltu;     // unsigned a < b
  logic          eq;
  logic [4:0]    shamt;

  // anything but add needs a - b, the logic ops just ignore sum
  assign do_sub = (op != rv_pkg::ALU_ADD);
  assign b_eff  = b ^ {rv_pkg::XLEN{do_sub}};

  assign {carry, sum} = {1'b0, a} + {1'b0, b_eff} + {{rv_pkg::XLEN{1'b0}}, do_sub};

  // signed overflow flips the sign of the difference
  assign ovf = (a[31] == b_eff[31]) && (sum[31] != a[31]);
  assign lt  = sum[31] ^ ovf;
  assign ltu = ~carry;       // no carry out means a borrow
  assign eq  = (sum == '0);

  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD,
      rv_pkg::ALU_SUB:  result = sum;
      rv_pkg::ALU_XOR:  result = a ^ b;
      rv_pkg::ALU_OR:   result = a | b;
      rv_pkg::ALU_AND:  result = a & b;
      rv_pkg::ALU_SLT:  result = {{(rv_pkg::XLEN-1){1'b0}}, lt};
      rv_pkg::ALU_SLTU: result = {{(rv_pkg::XLEN-1){1'b0}}, ltu};
      rv_pkg::ALU_SLL:  result = a << shamt;
      rv_pkg::ALU_SRL:  result = a >> shamt;
      rv_pkg::ALU_SRA:  result = rv_pkg::word_t'($signed(a) >>> shamt);
      default:          result = '0;
    endcase
  end

  // only meaningful for branches, the core masks it otherwise
  always_comb begin
    case (funct3)
      rv_pkg::F3_BEQ:  cond = eq;
      rv_pkg::F3_BNE:  cond = ~eq;
      rv_pkg::F3_BLT:  cond = lt;
      rv_pkg::F3_BGE:  cond = ~lt;
      rv_pkg::F3_BLTU: cond = ltu;
      rv_pkg::F3_BGEU: cond = ~ltu;
      default:         cond = 1'b0;
    endcase
  end

endmodule

/* source/decoder.sv */
`timescale 1ns/100ps

module decoder (
  input  rv_pkg::word_t    insn,
  output logic             reg_we,
  output rv_pkg::alu_op_t  alu_op,
  output logic             use_imm,
  output rv_pkg::imm_sel_t imm_sel,
  output rv_pkg::wb_sel_t  wb_sel,
  output logic             is_branch,
  output logic             is_jal,
  output logic             is_jalr,
  output logic             is_store,
  output logic             halt
);

  logic [6:0]       opcode;
  rv_pkg::funct3_t  funct3;
  logic             f7_alt;   // funct7 bit 30, sub / sra
  rv_pkg::alu_op_t  arith_op;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign f7_alt = insn[30];

  // shared by OP_REG and OP_IMM, addi has no subtract form
  always_comb begin
    case (funct3)
      rv_pkg::F3_ADD:  arith_op = (f7_alt && opcode == rv_pkg::OP_REG) ? rv_pkg::ALU_SUB
                                                                      : rv_pkg::ALU_ADD;
      rv_pkg::F3_SLL:  arith_op = rv_pkg::ALU_SLL;
      rv_pkg::F3_SLT:  arith_op = rv_pkg::ALU_SLT;
      rv_pkg::F3_SLTU: arith_op = rv_pkg::ALU_SLTU;
      rv_pkg::F3_XOR:  arith_op = rv_pkg::ALU_XOR;
      rv_pkg::F3_SR:   arith_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      rv_pkg::F3_OR:   arith_op = rv_pkg::ALU_OR;
      default:         arith_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    reg_we    = 1'b0;
    alu_op    = rv_pkg::ALU_ADD;
    use_imm   = 1'b0;
    imm_sel   = rv_pkg::IMM_I;
    wb_sel    = rv_pkg::WB_ALU;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_store  = 1'b0;
    halt      = 1'b0;
    case (opcode)
      rv_pkg::OP_LUI: begin
        reg_we  = 1'b1;
        imm_sel = rv_pkg::IMM_U;
        wb_sel  = rv_pkg::WB_IMM;
      end
      rv_pkg::OP_AUIPC: begin
        reg_we  = 1'b1;
        imm_sel = rv_pkg::IMM_U;
        wb_sel  = rv_pkg::WB_PCREL;
      end
      rv_pkg::OP_JAL: begin
        reg_we  = 1'b1;
        imm_sel = rv_pkg::IMM_J;
        wb_sel  = rv_pkg::WB_PC4;
        is_jal  = 1'b1;
      end
      rv_pkg::OP_JALR: begin
        reg_we  = 1'b1;
        wb_sel  = rv_pkg::WB_PC4;
        is_jalr = 1'b1;
      end
      rv_pkg::OP_BRANCH: begin
        alu_op    = rv_pkg::ALU_SUB; // comparator runs off the subtractor
        imm_sel   = rv_pkg::IMM_B;
        is_branch = 1'b1;
      end
      rv_pkg::OP_LOAD: begin
        reg_we  = 1'b1;
        use_imm = 1'b1;
        wb_sel  = rv_pkg::WB_LOAD;
      end
      rv_pkg::OP_STORE: begin
        use_imm  = 1'b1;
        imm_sel  = rv_pkg::IMM_S;
        is_store = 1'b1;
      end
      rv_pkg::OP_IMM: begin
        reg_we  = 1'b1;
        use_imm = 1'b1;
        alu_op  = arith_op;
      end
      rv_pkg::OP_REG: begin
        reg_we = 1'b1;
        alu_op = arith_op;
      end
      rv_pkg::OP_SYSTEM: begin
        halt = (insn == rv_pkg::EBREAK_INSN); // other system insns are no-ops
      end
      default: ;
    endcase
  end

endmodule

/* source/imm_gen.sv */
`timescale 1ns/100ps

module imm_gen (
  input  rv_pkg::word_t    insn,
  input  rv_pkg::imm_sel_t imm_sel,
  output rv_pkg::word_t    imm
);

  logic       shift_imm; // slli, srli, srai
  logic [6:0] opcode;
  rv_pkg::funct3_t funct3;

  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];

  assign shift_imm = (opcode == rv_pkg::OP_IMM) &&
                     ((funct3 == rv_pkg::F3_SLL) || (funct3 == rv_pkg::F3_SR));

  always_comb begin
    case (imm_sel)
      rv_pkg::IMM_I: begin
        if (shift_imm) begin
          imm = {27'b0, insn[24:20]}; // shamt only, drop the funct7 bits
        end else begin
          imm = {{20{insn[31]}}, insn[31:20]};
        end
      end
      rv_pkg::IMM_S: begin
        imm = {{20{insn[31]}}, insn[31:25], insn[11:7]};
      end
      rv_pkg::IMM_B: begin
        // branch offsets are in halfwords
        imm = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
      end
      rv_pkg::IMM_U: begin
        imm = {insn[31:12], 12'b0};
      end
      rv_pkg::IMM_J: begin
        imm = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

/* source/reg_file.sv */
`timescale 1ns/100ps

module reg_file (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             we,
  input  rv_pkg::reg_idx_t waddr,
  input  rv_pkg::word_t    wdata,
  input  rv_pkg::reg_idx_t rs1_addr,
  input  rv_pkg::reg_idx_t rs2_addr,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);

  rv_pkg::word_t regs [32];

  // x0 is never written, so it keeps its reset value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      regs <= '{default: '0};
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, same cycle as decode
  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

  // x0 reads zero through either port across any write sequence
  a_x0_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    ((rs1_addr == '0) |-> (rs1_data == '0)) and ((rs2_addr == '0) |-> (rs2_data == '0))
  ) else $error("reg_file: x0 read back nonzero");

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;     // data, address or instruction
  typedef logic [4:0]      reg_idx_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [3:0]      byte_mask_t; // one bit per byte lane
  typedef logic [3:0]      alu_op_t;
  typedef logic [2:0]      wb_sel_t;
  typedef logic [2:0]      imm_sel_t;

  localparam word_t RESET_PC = 32'h8000_0000;

  // major opcodes, insn[6:0]
  localparam logic [6:0] OP_LUI    = 7'b011_0111;
  localparam logic [6:0] OP_AUIPC  = 7'b001_0111;
  localparam logic [6:0] OP_JAL    = 7'b110_1111;
  localparam logic [6:0] OP_JALR   = 7'b110_0111;
  localparam logic [6:0] OP_BRANCH = 7'b110_0011;
  localparam logic [6:0] OP_LOAD   = 7'b000_0011;
  localparam logic [6:0] OP_STORE  = 7'b010_0011;
  localparam logic [6:0] OP_IMM    = 7'b001_0011;
  localparam logic [6:0] OP_REG    = 7'b011_0011;
  localparam logic [6:0] OP_SYSTEM = 7'b111_0011;

  // loads
  localparam funct3_t F3_LB  = 3'b000;
  localparam funct3_t F3_LH  = 3'b001;
  localparam funct3_t F3_LW  = 3'b010;
  localparam funct3_t F3_LBU = 3'b100;
  localparam funct3_t F3_LHU = 3'b101;
  // stores
  localparam funct3_t F3_SB  = 3'b000;
  localparam funct3_t F3_SH  = 3'b001;
  localparam funct3_t F3_SW  = 3'b010;
  // branches
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;
  // register and immediate arithmetic
  localparam funct3_t F3_ADD  = 3'b000; // add, sub, addi
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101; // srl and sra
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_XOR  = 4'd2;
  localparam alu_op_t ALU_OR   = 4'd3;
  localparam alu_op_t ALU_AND  = 4'd4;
  localparam alu_op_t ALU_SLT  = 4'd5;
  localparam alu_op_t ALU_SLTU = 4'd6;
  localparam alu_op_t ALU_SLL  = 4'd7;
  localparam alu_op_t ALU_SRL  = 4'd8;
  localparam alu_op_t ALU_SRA  = 4'd9;

  localparam wb_sel_t WB_ALU   = 3'd0;
  localparam wb_sel_t WB_LOAD  = 3'd1;
  localparam wb_sel_t WB_PC4   = 3'd2; // link address
  localparam wb_sel_t WB_IMM   = 3'd3; // lui
  localparam wb_sel_t WB_PCREL = 3'd4; // auipc

  localparam imm_sel_t IMM_I = 3'd0;
  localparam imm_sel_t IMM_S = 3'd1;
  localparam imm_sel_t IMM_B = 3'd2;
  localparam imm_sel_t IMM_U = 3'd3;
  localparam imm_sel_t IMM_J = 3'd4;

  localparam word_t EBREAK_INSN = 32'h0010_0073;

endpackage
